/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // data widths with a meaning on the board
    typedef logic [31:0] word_t;    // addresses and bus data
    typedef logic [7:0]  byte_t;    // switches, leds, char and color codes
    typedef logic [4:0]  key_t;     // [4] key pressed, [3:0] key code
    typedef logic [10:0] cell_t;    // screen cell index

    // shared bus owner
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_t;

    localparam int RAM_WORDS  = 1024;
    localparam int TEXT_CELLS = 2048;

    // address map, upper bits
    localparam logic [15:0] IO_PAGE    = 16'hffff;    // adr[31:16]
    localparam logic [19:0] CHAR_PAGE  = 20'hffffe;   // adr[31:12]
    localparam logic [19:0] COLOR_PAGE = 20'hffffd;   // adr[31:12]

    // io register addresses
    localparam word_t SW1_ADDR       = 32'hffff_ff00;
    localparam word_t SW2_ADDR       = 32'hffff_ff04;
    localparam word_t SW3_ADDR       = 32'hffff_ff08;
    localparam word_t LED1_ADDR      = 32'hffff_ff0c;
    localparam word_t LED2_ADDR      = 32'hffff_ff10;
    localparam word_t BTN_ADDR       = 32'hffff_ff14;   // five buttons, 4 bytes apart
    localparam word_t SEPC_ADDR      = 32'hffff_ff28;
    localparam word_t SEG1_ADDR      = 32'hffff_ff2c;
    localparam word_t SEG2_ADDR      = 32'hffff_ff30;
    localparam word_t KEY_VALID_ADDR = 32'hffff_ff34;
    localparam word_t KEY_CODE_ADDR  = 32'hffff_ff38;

endpackage

`default_nettype wire

/* hw/bus_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_interconnect (
    input  logic           clk,
    input  logic           reset,
    // fetch master, read only
    input  logic           f_cyc,
    input  logic           f_stb,
    input  soc_pkg::word_t f_adr,
    output soc_pkg::word_t f_dat_r,
    output logic           f_ack,
    // load/store master
    input  logic           d_cyc,
    input  logic           d_stb,
    input  logic           d_we,
    input  soc_pkg::word_t d_adr,
    input  soc_pkg::word_t d_dat_w,
    output soc_pkg::word_t d_dat_r,
    output logic           d_ack,
    // shared slave side
    output soc_pkg::word_t bus_adr,
    output soc_pkg::word_t bus_dat_w,
    output logic           bus_we,
    output logic           ram_stb,
    output logic           io_stb,
    output logic           text_stb,
    input  soc_pkg::word_t ram_dat_r,
    input  soc_pkg::word_t io_dat_r,
    input  soc_pkg::word_t text_dat_r,
    input  logic           ram_ack,
    input  logic           io_ack,
    input  logic           text_ack
);

    soc_pkg::arb_state_t state, state_next;
    logic           last_data;          // data master won the last grant
    logic           f_req, d_req;
    logic           grant_f, grant_d;
    logic           bus_stb;
    logic           sel_ram, sel_io, sel_text;
    logic           sel_ack;
    soc_pkg::word_t sel_dat;

    assign f_req   = f_cyc && f_stb;
    assign d_req   = d_cyc && d_stb;
    assign grant_f = (state == soc_pkg::ARB_FETCH);
    assign grant_d = (state == soc_pkg::ARB_DATA);

    always_comb begin
        state_next = state;
        case (state)
            soc_pkg::ARB_IDLE: begin
                if (f_req && d_req) begin
                    // round robin, the other one goes first
                    state_next = last_data ? soc_pkg::ARB_FETCH : soc_pkg::ARB_DATA;
                end else if (f_req) begin
                    state_next = soc_pkg::ARB_FETCH;
                end else if (d_req) begin
                    state_next = soc_pkg::ARB_DATA;
                end
            end
            soc_pkg::ARB_FETCH: begin
                if (!f_cyc || f_ack) begin  // master drops cyc on the ack edge
                    state_next = soc_pkg::ARB_IDLE;
                end
            end
            soc_pkg::ARB_DATA: begin
                if (!d_cyc || d_ack) begin
                    state_next = soc_pkg::ARB_IDLE;
                end
            end
            default: state_next = soc_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= soc_pkg::ARB_IDLE;
            last_data <= 1'b0;
        end else begin
            state <= state_next;
            if (state == soc_pkg::ARB_IDLE && state_next != soc_pkg::ARB_IDLE) begin
                last_data <= (state_next == soc_pkg::ARB_DATA);
            end
        end
    end

    // granted master drives the shared bus
    assign bus_adr   = grant_d ? d_adr : f_adr;
    assign bus_dat_w = d_dat_w;
    assign bus_we    = grant_d && d_we;     // fetch port never writes
    assign bus_stb   = (grant_f && f_stb) || (grant_d && d_stb);

    // screen pages sit inside the io page, so they win first
    assign sel_text = (bus_adr[31:12] == soc_pkg::CHAR_PAGE)
                   || (bus_adr[31:12] == soc_pkg::COLOR_PAGE);
    assign sel_io   = (bus_adr[31:16] == soc_pkg::IO_PAGE) && !sel_text;
    assign sel_ram  = !sel_io && !sel_text;

    assign ram_stb  = bus_stb && sel_ram;
    assign io_stb   = bus_stb && sel_io;
    assign text_stb = bus_stb && sel_text;

    always_comb begin
        if (sel_text) begin
            sel_dat = text_dat_r;
            sel_ack = text_ack;
        end else if (sel_io) begin
            sel_dat = io_dat_r;
            sel_ack = io_ack;
        end else begin
            sel_dat = ram_dat_r;
            sel_ack = ram_ack;
        end
    end

    assign f_ack   = grant_f && sel_ack;
    assign d_ack   = grant_d && sel_ack;
    assign f_dat_r = grant_f ? sel_dat : '0;
    assign d_dat_r = grant_d ? sel_dat : '0;

endmodule

`default_nettype wire

/* hw/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic           clk,
    input  logic           reset,
    input  logic           stb,
    input  logic           we,
    input  soc_pkg::word_t adr,
    input  soc_pkg::word_t dat_w,
    output soc_pkg::word_t dat_r,
    output logic           ack
);

    soc_pkg::word_t mem [soc_pkg::RAM_WORDS];
    logic [9:0]     idx;
    logic           access;

    assign idx    = adr[11:2];      // word index, aliases above bit 11
    assign access = stb && !ack;    // new request this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;          // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we) begin
                mem[idx] <= dat_w;
            end
            dat_r <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* hw/io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module io_regs (
    input  logic           clk,
    input  logic           reset,
    input  logic           stb,
    input  logic           we,
    input  soc_pkg::word_t adr,
    input  soc_pkg::word_t dat_w,
    output soc_pkg::word_t dat_r,
    output logic           ack,
    // board inputs
    input  soc_pkg::byte_t switches1,
    input  soc_pkg::byte_t switches2,
    input  soc_pkg::byte_t switches3,
    input  logic [4:0]     buttons,     // [0] middle, up, down, left, [4] right
    input  soc_pkg::word_t sepc,
    input  soc_pkg::key_t  kb_idx,
    // board outputs
    output soc_pkg::byte_t led1,
    output soc_pkg::byte_t led2,
    output soc_pkg::word_t seg1,
    output soc_pkg::word_t seg2
);

    soc_pkg::word_t rd_val;
    logic           access;

    assign access = stb && !ack;

    // read mux, registered below
    always_comb begin
        rd_val = '0;    // unmapped addresses read zero
        case (adr)
            soc_pkg::SW1_ADDR:       rd_val = {24'h0, switches1};
            soc_pkg::SW2_ADDR:       rd_val = {24'h0, switches2};
            soc_pkg::SW3_ADDR:       rd_val = {24'h0, switches3};
            soc_pkg::LED1_ADDR:      rd_val = {24'h0, led1};
            soc_pkg::LED2_ADDR:      rd_val = {24'h0, led2};
            soc_pkg::SEPC_ADDR:      rd_val = sepc;
            soc_pkg::SEG1_ADDR:      rd_val = seg1;
            soc_pkg::SEG2_ADDR:      rd_val = seg2;
            soc_pkg::KEY_VALID_ADDR: rd_val = {31'h0, kb_idx[4]};
            soc_pkg::KEY_CODE_ADDR:  rd_val = {28'h0, kb_idx[3:0]};
            default: begin
                // buttons occupy five consecutive words
                for (int i = 0; i < 5; i++) begin
                    if (adr == soc_pkg::BTN_ADDR + soc_pkg::word_t'(4 * i)) begin
                        rd_val = {31'h0, buttons[i]};
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack  <= 1'b0;
            led1 <= '0;
            led2 <= '0;
            seg1 <= '0;
            seg2 <= '0;
        end else begin
            ack <= access;
            if (access && we) begin
                case (adr)
                    soc_pkg::LED1_ADDR: led1 <= dat_w[7:0];     // low byte only
                    soc_pkg::LED2_ADDR: led2 <= dat_w[7:0];
                    soc_pkg::SEG1_ADDR: seg1 <= dat_w;
                    soc_pkg::SEG2_ADDR: seg2 <= dat_w;
                    default: ;                                  // read-only or unmapped
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_r <= rd_val;
        end
    end

endmodule

`default_nettype wire

/* hw/text_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module text_buffer (
    input  logic           clk,
    input  logic           reset,
    input  logic           stb,
    input  logic           we,
    input  soc_pkg::word_t adr,
    input  soc_pkg::word_t dat_w,
    output soc_pkg::word_t dat_r,
    output logic           ack,
    // display scanner side
    input  soc_pkg::cell_t vga_addr,
    output soc_pkg::byte_t char_out,
    output soc_pkg::byte_t color_out
);

    soc_pkg::byte_t char_mem  [soc_pkg::TEXT_CELLS];
    soc_pkg::byte_t color_mem [soc_pkg::TEXT_CELLS];
    soc_pkg::cell_t idx;
    logic           is_char;    // else color page
    logic           access;

    assign idx     = adr[10:0];
    assign is_char = (adr[31:12] == soc_pkg::CHAR_PAGE);
    assign access  = stb && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we && is_char) begin
                char_mem[idx] <= dat_w[7:0];
            end
            if (we && !is_char) begin
                color_mem[idx] <= dat_w[7:0];
            end
            dat_r <= {24'h0, is_char ? char_mem[idx] : color_mem[idx]};
        end
    end

    // scanner reads without a clock
    assign char_out  = char_mem[vga_addr];
    assign color_out = color_mem[vga_addr];

endmodule

`default_nettype wire

/* hw/soc_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_memory (
    input  logic           clk,
    input  logic           reset,
    // instruction fetch port
    input  logic           f_cyc,
    input  logic           f_stb,
    input  soc_pkg::word_t f_adr,
    output soc_pkg::word_t f_dat_r,
    output logic           f_ack,
    // load/store port
    input  logic           d_cyc,
    input  logic           d_stb,
    input  logic           d_we,
    input  soc_pkg::word_t d_adr,
    input  soc_pkg::word_t d_dat_w,
    output soc_pkg::word_t d_dat_r,
    output logic           d_ack,
    // board io
    input  soc_pkg::byte_t switches1,
    input  soc_pkg::byte_t switches2,
    input  soc_pkg::byte_t switches3,
    input  logic [4:0]     buttons,     // middle, up, down, left, right
    input  soc_pkg::word_t sepc,
    input  soc_pkg::key_t  kb_idx,
    input  soc_pkg::cell_t vga_addr,
    output soc_pkg::word_t seg1,
    output soc_pkg::word_t seg2,
    output soc_pkg::byte_t led1,
    output soc_pkg::byte_t led2,
    output soc_pkg::byte_t char_out,
    output soc_pkg::byte_t color_out
);

    soc_pkg::word_t bus_adr, bus_dat_w;
    logic           bus_we;
    logic           ram_stb, io_stb, text_stb;
    soc_pkg::word_t ram_dat_r, io_dat_r, text_dat_r;
    logic           ram_ack, io_ack, text_ack;

    bus_interconnect bus_interconnect_i (
        .clk, .reset,
        .f_cyc, .f_stb, .f_adr, .f_dat_r, .f_ack,
        .d_cyc, .d_stb, .d_we, .d_adr, .d_dat_w, .d_dat_r, .d_ack,
        .bus_adr, .bus_dat_w, .bus_we,
        .ram_stb, .io_stb, .text_stb,
        .ram_dat_r, .io_dat_r, .text_dat_r,
        .ram_ack, .io_ack, .text_ack
    );

    data_ram data_ram_i (
        .clk, .reset,
        .stb   (ram_stb),
        .we    (bus_we),
        .adr   (bus_adr),
        .dat_w (bus_dat_w),
        .dat_r (ram_dat_r),
        .ack   (ram_ack)
    );

    io_regs io_regs_i (
        .clk, .reset,
        .stb   (io_stb),
        .we    (bus_we),
        .adr   (bus_adr),
        .dat_w (bus_dat_w),
        .dat_r (io_dat_r),
        .ack   (io_ack),
        .switches1, .switches2, .switches3, .buttons, .sepc, .kb_idx,
        .led1, .led2, .seg1, .seg2
    );

    text_buffer text_buffer_i (
        .clk, .reset,
        .stb   (text_stb),
        .we    (bus_we),
        .adr   (bus_adr),
        .dat_w (bus_dat_w),
        .dat_r (text_dat_r),
        .ack   (text_ack),
        .vga_addr, .char_out, .color_out
    );

endmodule

`default_nettype wire

/* tb/soc_memory_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_memory_assertions (
    input logic clk,
    input logic reset,
    input logic ram_stb,
    input logic io_stb,
    input logic text_stb,
    input logic ram_ack,
    input logic io_ack,
    input logic text_ack,
    input logic f_ack,
    input logic d_ack
);

    // a slave acks only the cycle after its own strobe
    ram_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
        ram_ack |-> $past(ram_stb)) else $error("ram ack without a ram strobe");
    io_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
        io_ack |-> $past(io_stb)) else $error("io ack without an io strobe");
    text_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
        text_ack |-> $past(text_stb)) else $error("text ack without a text strobe");

    one_slave_selected: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ram_stb, io_stb, text_stb})) else $error("two slave strobes high");

    master_acks_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(f_ack && d_ack)) else $error("fetch and data ack high together");

endmodule

bind soc_memory soc_memory_assertions soc_memory_assertions_i (
    .clk, .reset,
    .ram_stb, .io_stb, .text_stb,
    .ram_ack, .io_ack, .text_ack,
    .f_ack, .d_ack
);

`default_nettype wire

/* tb/tb_soc_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_memory;

    localparam int N_RAM   = 40;    // write, two reads and an alias read each
    localparam int N_IO    = 3;     // rounds over all 15 readable io words
    localparam int N_UNDEF = 8;
    localparam int N_OUT   = 4;
    localparam int N_TXT   = 24;
    localparam int N_MIX   = 60;    // per master in the shared phase
    localparam int XFERS   = 4 * N_RAM + 15 * N_IO + 2 * N_UNDEF + 8 * N_OUT
                           + 4 * N_TXT + 2 * N_MIX;
    localparam int TIMEOUT_CYCLES = 6 * XFERS + 2 * N_TXT + 10;
    localparam int SOLO_WAIT   = 2; // grant, then ack
    localparam int SHARED_WAIT = 5; // other transfer, back to idle, then own two

    logic           clk = 1'b0;
    logic           reset;
    logic           f_cyc;
    logic           f_stb;
    soc_pkg::word_t f_adr;
    soc_pkg::word_t f_dat_r;
    logic           f_ack;
    logic           d_cyc;
    logic           d_stb;
    logic           d_we;
    soc_pkg::word_t d_adr;
    soc_pkg::word_t d_dat_w;
    soc_pkg::word_t d_dat_r;
    logic           d_ack;
    soc_pkg::byte_t switches1;
    soc_pkg::byte_t switches2;
    soc_pkg::byte_t switches3;
    logic [4:0]     buttons;
    soc_pkg::word_t sepc;
    soc_pkg::key_t  kb_idx;
    soc_pkg::cell_t vga_addr;
    soc_pkg::word_t seg1;
    soc_pkg::word_t seg2;
    soc_pkg::byte_t led1;
    soc_pkg::byte_t led2;
    soc_pkg::byte_t char_out;
    soc_pkg::byte_t color_out;

    // reference model
    soc_pkg::word_t ram_model   [soc_pkg::RAM_WORDS];
    bit             ram_known   [soc_pkg::RAM_WORDS];
    soc_pkg::byte_t char_model  [soc_pkg::TEXT_CELLS];
    bit             char_known  [soc_pkg::TEXT_CELLS];
    soc_pkg::byte_t color_model [soc_pkg::TEXT_CELLS];
    bit             color_known [soc_pkg::TEXT_CELLS];
    soc_pkg::byte_t led1_m = '0;
    soc_pkg::byte_t led2_m = '0;
    soc_pkg::word_t seg1_m = '0;
    soc_pkg::word_t seg2_m = '0;
    soc_pkg::word_t ram_addrs [$];  // written words, safe to read
    soc_pkg::word_t text_addrs [$];

    soc_pkg::word_t seed = 32'h8fef;
    int             max_wait = SOLO_WAIT;
    int             cycle_count = 0;

    soc_memory soc_memory_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles, a transfer never finished",
                     TIMEOUT_CYCLES);
            abort_run();
        end
    end

    function automatic soc_pkg::word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input soc_pkg::word_t got,
                               input soc_pkg::word_t exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_wait(input string name, input int cycles);
        assert (cycles <= max_wait) else begin
            $display("Error at %0t ns: %s = %0d cycles, expected at most %0d",
                     $time, name, cycles, max_wait);
            abort_run();
        end
    endtask

    function automatic soc_pkg::word_t ram_addr(input soc_pkg::word_t r);
        return {1'b0, r[30:2], 2'b00};      // bit 31 low keeps it off the io page
    endfunction

    function automatic soc_pkg::word_t text_addr(input logic is_char, input soc_pkg::word_t r);
        return {is_char ? soc_pkg::CHAR_PAGE : soc_pkg::COLOR_PAGE, r[20], r[26:16]};
    endfunction

    function automatic soc_pkg::word_t out_addr(input logic [1:0] k);
        case (k)
            2'd0:    return soc_pkg::LED1_ADDR;
            2'd1:    return soc_pkg::LED2_ADDR;
            2'd2:    return soc_pkg::SEG1_ADDR;
            default: return soc_pkg::SEG2_ADDR;
        endcase
    endfunction

    function automatic soc_pkg::word_t io_addr(input int k);
        case (k)
            0:       return soc_pkg::SW1_ADDR;
            1:       return soc_pkg::SW2_ADDR;
            2:       return soc_pkg::SW3_ADDR;
            3:       return soc_pkg::LED1_ADDR;
            4:       return soc_pkg::LED2_ADDR;
            5:       return soc_pkg::SEG1_ADDR;
            6:       return soc_pkg::SEG2_ADDR;
            7:       return soc_pkg::SEPC_ADDR;
            8:       return soc_pkg::KEY_VALID_ADDR;
            9:       return soc_pkg::KEY_CODE_ADDR;
            default: return soc_pkg::BTN_ADDR + soc_pkg::word_t'(4 * (k - 10));
        endcase
    endfunction

    // returns 0 when the location was never written
    function automatic logic expect_read(input soc_pkg::word_t adr,
                                         output soc_pkg::word_t exp);
        exp = '0;
        if (adr[31:12] == soc_pkg::CHAR_PAGE) begin
            exp = {24'h0, char_model[adr[10:0]]};
            return char_known[adr[10:0]];
        end
        if (adr[31:12] == soc_pkg::COLOR_PAGE) begin
            exp = {24'h0, color_model[adr[10:0]]};
            return color_known[adr[10:0]];
        end
        if (adr[31:16] != soc_pkg::IO_PAGE) begin
            exp = ram_model[adr[11:2]];
            return ram_known[adr[11:2]];
        end
        case (adr)
            soc_pkg::SW1_ADDR:              exp = {24'h0, switches1};
            soc_pkg::SW2_ADDR:              exp = {24'h0, switches2};
            soc_pkg::SW3_ADDR:              exp = {24'h0, switches3};
            soc_pkg::LED1_ADDR:             exp = {24'h0, led1_m};
            soc_pkg::LED2_ADDR:             exp = {24'h0, led2_m};
            soc_pkg::SEG1_ADDR:             exp = seg1_m;
            soc_pkg::SEG2_ADDR:             exp = seg2_m;
            soc_pkg::SEPC_ADDR:             exp = sepc;
            soc_pkg::KEY_VALID_ADDR:        exp = {31'h0, kb_idx[4]};
            soc_pkg::KEY_CODE_ADDR:         exp = {28'h0, kb_idx[3:0]};
            soc_pkg::BTN_ADDR:              exp = {31'h0, buttons[0]};
            soc_pkg::BTN_ADDR + 32'd4:      exp = {31'h0, buttons[1]};
            soc_pkg::BTN_ADDR + 32'd8:      exp = {31'h0, buttons[2]};
            soc_pkg::BTN_ADDR + 32'd12:     exp = {31'h0, buttons[3]};
            soc_pkg::BTN_ADDR + 32'd16:     exp = {31'h0, buttons[4]};
            default:                        exp = '0;
        endcase
        return 1'b1;
    endfunction

    function automatic void model_write(input soc_pkg::word_t adr, input soc_pkg::word_t dat);
        if (adr[31:12] == soc_pkg::CHAR_PAGE) begin
            char_model[adr[10:0]] = dat[7:0];
            char_known[adr[10:0]] = 1'b1;
        end else if (adr[31:12] == soc_pkg::COLOR_PAGE) begin
            color_model[adr[10:0]] = dat[7:0];
            color_known[adr[10:0]] = 1'b1;
        end else if (adr[31:16] != soc_pkg::IO_PAGE) begin
            ram_model[adr[11:2]] = dat;
            ram_known[adr[11:2]] = 1'b1;
        end else begin
            case (adr)
                soc_pkg::LED1_ADDR: led1_m = dat[7:0];
                soc_pkg::LED2_ADDR: led2_m = dat[7:0];
                soc_pkg::SEG1_ADDR: seg1_m = dat;
                soc_pkg::SEG2_ADDR: seg2_m = dat;
                default: ;
            endcase
        end
    endfunction

    task automatic data_access(input logic we, input soc_pkg::word_t adr,
                               input soc_pkg::word_t wdat, output soc_pkg::word_t rdat);
        int cycles;
        cycles = 0;
        @(negedge clk);
        d_cyc   = 1'b1;
        d_stb   = 1'b1;
        d_we    = we;
        d_adr   = adr;
        d_dat_w = wdat;
        do begin
            @(negedge clk);
            cycles++;
        end while (!d_ack);
        rdat  = d_dat_r;
        d_cyc = 1'b0;     // dropped right after ack
        d_stb = 1'b0;
        d_we  = 1'b0;
        check_wait("d_ack wait", cycles);
    endtask

    task automatic fetch_read(input soc_pkg::word_t adr, output soc_pkg::word_t rdat);
        int cycles;
        cycles = 0;
        @(negedge clk);
        f_cyc = 1'b1;
        f_stb = 1'b1;
        f_adr = adr;
        do begin
            @(negedge clk);
            cycles++;
        end while (!f_ack);
        rdat  = f_dat_r;
        f_cyc = 1'b0;
        f_stb = 1'b0;
        check_wait("f_ack wait", cycles);
    endtask

    task automatic check_read(input string name, input soc_pkg::word_t adr,
                              input soc_pkg::word_t got);
        soc_pkg::word_t exp;
        if (expect_read(adr, exp)) begin
            check_value($sformatf("%s from %h", name, adr), got, exp);
        end
    endtask

    task automatic write_data(input soc_pkg::word_t adr, input soc_pkg::word_t dat);
        soc_pkg::word_t unused;
        data_access(1'b1, adr, dat, unused);
        model_write(adr, dat);
    endtask

    task automatic read_data(input soc_pkg::word_t adr);
        soc_pkg::word_t got;
        data_access(1'b0, adr, '0, got);
        check_read("d_dat_r", adr, got);
    endtask

    task automatic read_fetch(input soc_pkg::word_t adr);
        soc_pkg::word_t got;
        fetch_read(adr, got);
        check_read("f_dat_r", adr, got);
    endtask

    task automatic check_outputs();
        check_value("led1", {24'h0, led1}, {24'h0, led1_m});
        check_value("led2", {24'h0, led2}, {24'h0, led2_m});
        check_value("seg1", seg1, seg1_m);
        check_value("seg2", seg2, seg2_m);
    endtask

    task automatic randomize_inputs();
        soc_pkg::word_t r;
        r = next_rand();
        switches1 = r[31:24];
        switches2 = r[23:16];
        switches3 = r[15:8];
        buttons   = r[28:24] ^ r[20:16];
        sepc      = next_rand();
        r         = next_rand();
        kb_idx    = r[30:26];
    endtask

    task automatic data_mix();
        soc_pkg::word_t r;
        soc_pkg::word_t adr;
        for (int i = 0; i < N_MIX; i++) begin
            r = next_rand();
            case (r[31:29])
                3'd0, 3'd1: begin
                    adr = ram_addr(next_rand());
                    write_data(adr, next_rand());
                    ram_addrs.push_back(adr);
                end
                3'd2: read_data(ram_addrs[next_rand() % ram_addrs.size()]);
                3'd3: begin
                    adr = text_addr(r[28], next_rand());
                    write_data(adr, next_rand());
                    text_addrs.push_back(adr);
                end
                3'd4: read_data(text_addrs[next_rand() % text_addrs.size()]);
                3'd5: write_data(out_addr(r[27:26]), next_rand());
                default: read_data(io_addr(int'(r[25:22]) % 15));
            endcase
        end
    endtask

    task automatic fetch_mix();
        soc_pkg::word_t r;
        for (int i = 0; i < N_MIX; i++) begin
            r = next_rand();
            case (r[31:30])
                2'd0, 2'd1: read_fetch(ram_addrs[next_rand() % ram_addrs.size()]);
                2'd2:       read_fetch(text_addrs[next_rand() % text_addrs.size()]);
                default:    read_fetch(io_addr(int'(r[25:22]) % 15));
            endcase
        end
    endtask

    initial begin
        soc_pkg::word_t r;
        soc_pkg::word_t adr;
        reset     = 1'b1;
        f_cyc     = 1'b0;
        f_stb     = 1'b0;
        f_adr     = '0;
        d_cyc     = 1'b0;
        d_stb     = 1'b0;
        d_we      = 1'b0;
        d_adr     = '0;
        d_dat_w   = '0;
        switches1 = '0;
        switches2 = '0;
        switches3 = '0;
        buttons   = '0;
        sepc      = '0;
        kb_idx    = '0;
        vga_addr  = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // state right after reset
        check_value("f_ack", {31'h0, f_ack}, 32'h0);
        check_value("d_ack", {31'h0, d_ack}, 32'h0);
        check_outputs();

        // ram through both ports, plus aliasing above bit 11
        for (int i = 0; i < N_RAM; i++) begin
            adr = ram_addr(next_rand());
            write_data(adr, next_rand());
            ram_addrs.push_back(adr);
            read_data(adr);
            read_fetch(adr);
            r = next_rand();
            read_fetch(adr ^ {1'b0, r[30:12], 12'h000});
        end

        // board inputs
        for (int n = 0; n < N_IO; n++) begin
            randomize_inputs();
            for (int k = 0; k < 15; k++) begin
                if (k[0]) begin
                    read_fetch(io_addr(k));
                end else begin
                    read_data(io_addr(k));
                end
            end
        end
        for (int i = 0; i < N_UNDEF; i++) begin
            r   = next_rand();
            adr = {16'hffff, 4'h0, r[27:18], 2'b00};   // unmapped io words
            write_data(adr, next_rand());
            read_data(adr);
        end

        // led and segment registers
        for (int n = 0; n < N_OUT; n++) begin
            for (int k = 0; k < 4; k++) begin
                write_data(out_addr(k[1:0]), next_rand());
                check_outputs();
                read_fetch(out_addr(k[1:0]));
            end
        end

        // screen buffer, bus side and scanner side
        for (int i = 0; i < N_TXT; i++) begin
            r = next_rand();
            write_data(text_addr(1'b1, r), next_rand());
            write_data(text_addr(1'b0, r), next_rand());
            text_addrs.push_back(text_addr(1'b1, r));
            text_addrs.push_back(text_addr(1'b0, r));
            vga_addr = r[26:16];
            @(negedge clk);
            check_value("char_out", {24'h0, char_out}, {24'h0, char_model[r[26:16]]});
            check_value("color_out", {24'h0, color_out}, {24'h0, color_model[r[26:16]]});
            read_data(text_addr(1'b1, r));
            read_fetch(text_addr(1'b0, r));
        end

        // both masters at once
        max_wait = SHARED_WAIT;
        fork
            data_mix();
            fetch_mix();
        join
        check_outputs();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hw/soc_pkg.sv
hw/bus_interconnect.sv
hw/data_ram.sv
hw/io_regs.sv
hw/text_buffer.sv
hw/soc_memory.sv
tb/soc_memory_assertions.sv
tb/tb_soc_memory.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_soc_memory \
        -f tb.f -o sim_tb_soc_memory; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_soc_memory 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" <<< "$output"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
